// ==== ex_defs.svh ====
// Pipeline width defines shared by the execute and write-back stages
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// ------------------------------------------------------------
// Datapath sizes fixed by the instruction set
// ------------------------------------------------------------

// Integer datapath, one register wide
`define DATA_W 32

// Register number, 32 architectural registers
`define REG_ADDR_W 5

// R-type funct field, low bits of the sign-extended immediate
`define FUNCT_W 6

`endif

// ==== isa_pkg.sv ====
// Instruction-set encodings for ALU decode and operand forwarding
`include "ex_defs.svh"

package isa_pkg;

	// Operation class handed over by the decoder
	typedef enum logic [1:0] {
		op_add   = 2'd0, // Loads, stores, addi
		op_sub   = 2'd1, // Branch compare
		op_rtype = 2'd2, // Look at funct
		op_and   = 2'd3  // andi
	} alu_op_e;

	// R-type funct codes handled here
	typedef enum logic [`FUNCT_W-1:0] {
		f_sra  = 6'd3,
		f_mul  = 6'd24,
		f_div  = 6'd26,
		f_add  = 6'd32, // Traps on overflow
		f_addu = 6'd33, // No overflow flag
		f_sub  = 6'd34,
		f_and  = 6'd36,
		f_or   = 6'd37,
		f_xor  = 6'd38,
		f_nor  = 6'd39,
		f_slt  = 6'd42
	} funct_e;

	// ALU operation select
	typedef enum logic [3:0] {
		ac_add  = 4'd0,
		ac_sub  = 4'd1,
		ac_and  = 4'd2,
		ac_or   = 4'd3,
		ac_xor  = 4'd4,
		ac_nor  = 4'd5,
		ac_slt  = 4'd6,
		ac_mul  = 4'd7,
		ac_div  = 4'd8,
		ac_sra  = 4'd9,
		ac_none = 4'd15 // Illegal op/funct pair, result forced to zero
	} alu_ctrl_e;

	// Where an ALU operand comes from
	typedef enum logic [1:0] {
		fw_reg = 2'd0, // Register file read
		fw_wb  = 2'd1, // Value being written back
		fw_mem = 2'd2  // EX/MEM result
	} fwd_sel_e;

endpackage

// ==== pipe_pkg.sv ====
// Pipeline register layouts for issue, EX/MEM and write-back
`include "ex_defs.svh"

package pipe_pkg;

	// ------------------------------------------------------------
	// Control groups carried down the pipe
	// ------------------------------------------------------------

	// Memory stage controls
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	// Write-back controls
	typedef struct packed {
		logic reg_write;  // Instruction writes a register
		logic mem_to_reg; // Take load data instead of ALU result
	} wb_ctrl_t;

	// ------------------------------------------------------------
	// Stage payloads
	// ------------------------------------------------------------

	// One decoded instruction entering execute
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`DATA_W-1:0]     data_1;  // Register file value of rs
		logic [`DATA_W-1:0]     data_2;  // Register file value of rt
		logic [`DATA_W-1:0]     imm;     // Sign-extended, funct in low bits
		isa_pkg::alu_op_e       alu_op;
		logic                   reg_dst; // Write rd, else rt
		logic                   alu_src; // Immediate as operand B
		mem_ctrl_t              mem;
		wb_ctrl_t               wb;
	} ex_issue_t;

	// EX/MEM register contents
	typedef struct packed {
		logic [`DATA_W-1:0]     result;
		logic [`DATA_W-1:0]     store_data; // Forwarded rt value
		logic [`REG_ADDR_W-1:0] dest;
		logic                   zero;
		logic                   overflow;
		mem_ctrl_t              mem;
		wb_ctrl_t               wb;
	} ex_mem_t;

	// Write-back bus, also the late forwarding source
	typedef struct packed {
		logic                   reg_write;
		logic [`REG_ADDR_W-1:0] dest;
		logic [`DATA_W-1:0]     data;
	} wb_bus_t;

endpackage

// ==== fwd_unit.sv ====
// Forwarding unit, picks the source of each ALU operand from EX/MEM or write-back
`timescale 1ns/1ps
`include "ex_defs.svh"

module fwd_unit (
	input  logic [`REG_ADDR_W-1:0] rs,     // Source of operand A
	input  logic [`REG_ADDR_W-1:0] rt,     // Source of operand B
	input  pipe_pkg::ex_mem_t      ex_mem, // Older instruction, one slot ahead
	input  pipe_pkg::wb_bus_t      wb,     // Oldest instruction, being written
	output isa_pkg::fwd_sel_e      fwd_a,
	output isa_pkg::fwd_sel_e      fwd_b
);

	// Priority pick for one source register
	// EX/MEM is the younger producer so it wins
	function automatic isa_pkg::fwd_sel_e pick_src(
		input logic [`REG_ADDR_W-1:0] src,
		input logic                   mem_we,
		input logic [`REG_ADDR_W-1:0] mem_dest,
		input logic                   wb_we,
		input logic [`REG_ADDR_W-1:0] wb_dest
	);
		if (mem_we && (mem_dest != '0) && (mem_dest == src))
			return isa_pkg::fw_mem;
		else if (wb_we && (wb_dest != '0) && (wb_dest == src))
			return isa_pkg::fw_wb;
		else
			return isa_pkg::fw_reg; // r0 and no hazard land here
	endfunction

	always_comb
	begin
		fwd_a = pick_src(rs, ex_mem.wb.reg_write, ex_mem.dest, wb.reg_write, wb.dest);
		fwd_b = pick_src(rt, ex_mem.wb.reg_write, ex_mem.dest, wb.reg_write, wb.dest);
	end

endmodule

// ==== alu_decode.sv ====
// ALU control decoder, maps operation class and funct code to an ALU operation
`timescale 1ns/1ps
`include "ex_defs.svh"

module alu_decode (
	input  isa_pkg::alu_op_e    alu_op,
	input  logic [`FUNCT_W-1:0] funct,   // Only meaningful for R-type
	output isa_pkg::alu_ctrl_e  alu_ctrl
);

	// ------------------------------------------------------------
	// Class decode, R-type falls through to funct
	// ------------------------------------------------------------
	always_comb
	begin
		case (alu_op)
			isa_pkg::op_add: alu_ctrl = isa_pkg::ac_add; // Address calc
			isa_pkg::op_sub: alu_ctrl = isa_pkg::ac_sub; // Compare
			isa_pkg::op_and: alu_ctrl = isa_pkg::ac_and;
			isa_pkg::op_rtype:
			begin
				case (funct)
					isa_pkg::f_sra:  alu_ctrl = isa_pkg::ac_sra;
					isa_pkg::f_mul:  alu_ctrl = isa_pkg::ac_mul;
					isa_pkg::f_div:  alu_ctrl = isa_pkg::ac_div;
					isa_pkg::f_add:  alu_ctrl = isa_pkg::ac_add;
					isa_pkg::f_addu: alu_ctrl = isa_pkg::ac_add; // Same sum, flag differs
					isa_pkg::f_sub:  alu_ctrl = isa_pkg::ac_sub;
					isa_pkg::f_and:  alu_ctrl = isa_pkg::ac_and;
					isa_pkg::f_or:   alu_ctrl = isa_pkg::ac_or;
					isa_pkg::f_xor:  alu_ctrl = isa_pkg::ac_xor;
					isa_pkg::f_nor:  alu_ctrl = isa_pkg::ac_nor;
					isa_pkg::f_slt:  alu_ctrl = isa_pkg::ac_slt;
					default:         alu_ctrl = isa_pkg::ac_none; // Unknown funct
				endcase
			end
			default: alu_ctrl = isa_pkg::ac_none;
		endcase
	end

endmodule

// ==== alu.sv ====
// 32-bit integer ALU with zero and signed-overflow flags
`timescale 1ns/1ps
`include "ex_defs.svh"

module alu (
	input  logic [`DATA_W-1:0]  op_a,
	input  logic [`DATA_W-1:0]  op_b,
	input  isa_pkg::alu_ctrl_e  alu_ctrl,
	input  logic [`FUNCT_W-1:0] funct,    // Tells add from addu for the flag
	output logic [`DATA_W-1:0]  result,
	output logic                zero,
	output logic                overflow
);

	logic [`DATA_W-1:0] sum;
	logic [`DATA_W-1:0] diff;
	logic               add_ovf;
	logic               sub_ovf;

	// Shared adder and subtractor, wrap at 32 bits
	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;

	// Signed overflow, sign of result disagrees with operands
	assign add_ovf = (op_a[`DATA_W-1] == op_b[`DATA_W-1]) &&
		(sum[`DATA_W-1] != op_a[`DATA_W-1]);
	assign sub_ovf = (op_a[`DATA_W-1] != op_b[`DATA_W-1]) &&
		(diff[`DATA_W-1] != op_a[`DATA_W-1]);

	// ------------------------------------------------------------
	// Result select
	// ------------------------------------------------------------
	always_comb
	begin
		case (alu_ctrl)
			isa_pkg::ac_add: result = sum;
			isa_pkg::ac_sub: result = diff;
			isa_pkg::ac_and: result = op_a & op_b;
			isa_pkg::ac_or:  result = op_a | op_b;
			isa_pkg::ac_xor: result = op_a ^ op_b;
			isa_pkg::ac_nor: result = ~(op_a | op_b);
			isa_pkg::ac_slt: result = {{(`DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			isa_pkg::ac_mul: result = op_a * op_b; // Low half only
			isa_pkg::ac_div:
			begin
				// Unsigned divide, divide by zero returns all ones
				if (op_b == '0)
					result = '1;
				else
					result = op_a / op_b;
			end
			isa_pkg::ac_sra: result = $signed(op_b) >>> op_a[4:0]; // Shamt from op_a
			default:         result = '0; // ac_none
		endcase
	end

	assign zero = (result == '0);

	// Only add and sub raise the flag; addu and the rest stay clear
	assign overflow = ((alu_ctrl == isa_pkg::ac_add) && (funct == isa_pkg::f_add) && add_ovf) ||
		((alu_ctrl == isa_pkg::ac_sub) && (funct == isa_pkg::f_sub) && sub_ovf);

endmodule

// ==== ex_stage.sv ====
// Execute stage with operand forwarding, ALU, destination select and EX/MEM register
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::ex_issue_t issue,
	input  logic                flush,  // Turn this issue into a bubble
	input  pipe_pkg::wb_bus_t   wb,     // Write-back bus for late forwarding
	output pipe_pkg::ex_mem_t   ex_mem
);

	// ------------------------------------------------------------
	// Operand paths
	// ------------------------------------------------------------
	isa_pkg::fwd_sel_e      fwd_a;
	isa_pkg::fwd_sel_e      fwd_b;
	isa_pkg::alu_ctrl_e     alu_ctrl;
	logic [`DATA_W-1:0]     op_a;
	logic [`DATA_W-1:0]     rt_val;     // Forwarded rt, before imm select
	logic [`DATA_W-1:0]     op_b;
	logic [`DATA_W-1:0]     alu_result;
	logic                   alu_zero;
	logic                   alu_overflow;
	logic [`FUNCT_W-1:0]    funct;
	logic [`REG_ADDR_W-1:0] dest;
	pipe_pkg::mem_ctrl_t    mem_ctrl;
	pipe_pkg::wb_ctrl_t     wb_ctrl;

	// Three-way operand mux, same for A and B
	function automatic logic [`DATA_W-1:0] fwd_mux(
		input isa_pkg::fwd_sel_e  sel,
		input logic [`DATA_W-1:0] reg_val,
		input logic [`DATA_W-1:0] wb_val,
		input logic [`DATA_W-1:0] mem_val
	);
		case (sel)
			isa_pkg::fw_mem: return mem_val;
			isa_pkg::fw_wb:  return wb_val;
			default:         return reg_val;
		endcase
	endfunction

	fwd_unit fwd_unit_i (
		.rs     (issue.rs),
		.rt     (issue.rt),
		.ex_mem (ex_mem),   // Our own register feeds the fw_mem path
		.wb     (wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	assign op_a   = fwd_mux(fwd_a, issue.data_1, wb.data, ex_mem.result);
	assign rt_val = fwd_mux(fwd_b, issue.data_2, wb.data, ex_mem.result);
	assign op_b   = issue.alu_src ? issue.imm : rt_val; // Immediate replaces B

	assign funct = issue.imm[`FUNCT_W-1:0]; // R-type funct rides in imm

	alu_decode alu_decode_i (
		.alu_op   (issue.alu_op),
		.funct    (funct),
		.alu_ctrl (alu_ctrl)
	);

	alu alu_i (
		.op_a     (op_a),
		.op_b     (op_b),
		.alu_ctrl (alu_ctrl),
		.funct    (funct),
		.result   (alu_result),
		.zero     (alu_zero),
		.overflow (alu_overflow)
	);

	// Destination register, rd for R-type
	assign dest = issue.reg_dst ? issue.rd : issue.rt;

	// Flush kills control only; data path still runs
	assign mem_ctrl = flush ? '0 : issue.mem;
	assign wb_ctrl  = flush ? '0 : issue.wb;

	// ------------------------------------------------------------
	// EX/MEM register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_mem <= '0; // Bubble after reset
		end
		else
		begin
			ex_mem.result     <= alu_result;
			ex_mem.store_data <= rt_val; // Never the immediate
			ex_mem.dest       <= dest;
			ex_mem.zero       <= alu_zero;
			ex_mem.overflow   <= alu_overflow;
			ex_mem.mem        <= mem_ctrl;
			ex_mem.wb         <= wb_ctrl;
		end
	end

endmodule

// ==== wb_stage.sv ====
// Write-back stage, MEM/WB register with ALU result or load data select
`timescale 1ns/1ps
`include "ex_defs.svh"

module wb_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  pipe_pkg::ex_mem_t  ex_mem,
	input  logic [`DATA_W-1:0] load_data, // Sampled at the transfer edge
	output pipe_pkg::wb_bus_t  wb
);

	logic [`DATA_W-1:0] wb_data;

	// Loads take memory data, everything else the ALU result
	assign wb_data = ex_mem.wb.mem_to_reg ? load_data : ex_mem.result;

	// MEM/WB register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb <= '0; // No write after reset
		end
		else
		begin
			wb.reg_write <= ex_mem.wb.reg_write;
			wb.dest      <= ex_mem.dest;
			wb.data      <= wb_data;
		end
	end

endmodule

// ==== ex_pipe_top.sv ====
// Execute and write-back pipeline top with the write-back forwarding loop
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_pipe_top (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::ex_issue_t issue,     // One instruction per clock
	input  logic                flush,
	input  logic [`DATA_W-1:0]  load_data, // Data memory read for loads
	output pipe_pkg::ex_mem_t   ex_mem,    // One cycle after issue
	output pipe_pkg::wb_bus_t   wb         // Two cycles after issue
);

	// ------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------

	// Execute, also sees wb for the older hazard
	ex_stage ex_stage_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (issue),
		.flush  (flush),
		.wb     (wb),
		.ex_mem (ex_mem)
	);

	// Write-back
	wb_stage wb_stage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_mem    (ex_mem),
		.load_data (load_data),
		.wb        (wb)
	);

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source, 4 ns clock with reset held for 8 cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk); // Release away from the active edge
		rst_n = 1'b1;
	end

endmodule

// ==== ex_pipe_props.sv ====
// Bound checks of forwarding, ALU results, flush and write-back on the pipeline ports
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_pipe_props (
	input logic                clk,
	input logic                rst_n,
	input pipe_pkg::ex_issue_t issue,
	input logic                flush,
	input logic [`DATA_W-1:0]  load_data,
	input pipe_pkg::ex_mem_t   ex_mem,
	input pipe_pkg::wb_bus_t   wb
);

	int err_cnt = 0; // Failed assertions so far

	logic [`DATA_W-1:0]     ref_a;
	logic [`DATA_W-1:0]     ref_rt;   // Forwarded rt, also the store data
	logic [`DATA_W-1:0]     ref_b;
	logic [`DATA_W-1:0]     ref_res;
	logic                   ref_ovf;
	logic [`REG_ADDR_W-1:0] ref_dest;
	logic [4:0]             ref_ctrl; // mem and wb fields after flush
	pipe_pkg::wb_bus_t      ref_wb;   // Next write-back from the current EX/MEM

	// Operand source, younger EX/MEM producer first, r0 never forwarded
	function automatic logic [`DATA_W-1:0] fwd_ref(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [`DATA_W-1:0]     reg_val,
		input pipe_pkg::ex_mem_t      m,
		input pipe_pkg::wb_bus_t      w
	);
		if (m.wb.reg_write && (m.dest != 0) && (m.dest == src))
			return m.result;
		if (w.reg_write && (w.dest != 0) && (w.dest == src))
			return w.data;
		return reg_val;
	endfunction

	// Overflow flag in the top bit, result below
	function automatic logic [`DATA_W:0] alu_ref(
		input logic [`DATA_W-1:0] a,
		input logic [`DATA_W-1:0] b,
		input isa_pkg::alu_op_e   op,
		input logic [`FUNCT_W-1:0] fn
	);
		logic [`DATA_W-1:0] r;
		logic               v;
		r = '0;
		case (op)
			isa_pkg::op_add: r = a + b;
			isa_pkg::op_sub: r = a - b;
			isa_pkg::op_and: r = a & b;
			default:
			begin
				case (fn)
					isa_pkg::f_add, isa_pkg::f_addu: r = a + b;
					isa_pkg::f_sub: r = a - b;
					isa_pkg::f_and: r = a & b;
					isa_pkg::f_or:  r = a | b;
					isa_pkg::f_xor: r = a ^ b;
					isa_pkg::f_nor: r = ~(a | b);
					isa_pkg::f_slt: r = {31'b0, $signed(a) < $signed(b)};
					isa_pkg::f_mul: r = a * b;
					isa_pkg::f_div: r = (b == 0) ? '1 : a / b;
					isa_pkg::f_sra: r = $signed(b) >>> a[4:0];
					default:        r = '0; // Illegal funct
				endcase
			end
		endcase
		// Flag only where the sum or difference carries funct add or sub
		v = (fn == isa_pkg::f_add) && (op == isa_pkg::op_add || op == isa_pkg::op_rtype) &&
			(a[31] == b[31]) && (r[31] != a[31]);
		v = v || ((fn == isa_pkg::f_sub) && (op == isa_pkg::op_sub || op == isa_pkg::op_rtype) &&
			(a[31] != b[31]) && (r[31] != a[31]));
		return {v, r};
	endfunction

	always_comb
	begin
		ref_a    = fwd_ref(issue.rs, issue.data_1, ex_mem, wb);
		ref_rt   = fwd_ref(issue.rt, issue.data_2, ex_mem, wb);
		ref_b    = issue.alu_src ? issue.imm : ref_rt;
		{ref_ovf, ref_res} = alu_ref(ref_a, ref_b, issue.alu_op, issue.imm[`FUNCT_W-1:0]);
		ref_dest = issue.reg_dst ? issue.rd : issue.rt;
		ref_ctrl = flush ? 5'b0 : {issue.mem, issue.wb};
		ref_wb.reg_write = ex_mem.wb.reg_write;
		ref_wb.dest      = ex_mem.dest;
		ref_wb.data      = ex_mem.wb.mem_to_reg ? load_data : ex_mem.result;
	end

	// ------------------------------------------------------------
	// EX/MEM one cycle after issue
	// ------------------------------------------------------------
	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ex_mem.result == $past(ref_res))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.result expected %h actual %h",
				$time, $past(ref_res), $sampled(ex_mem.result));
		end

	// Zero taken from the reference result
	a_zero: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ex_mem.zero == ($past(ref_res) == '0))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.zero expected %0b actual %0b",
				$time, $past(ref_res) == '0, $sampled(ex_mem.zero));
		end

	a_ovf: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ex_mem.overflow == $past(ref_ovf))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.overflow expected %0b actual %0b",
				$time, $past(ref_ovf), $sampled(ex_mem.overflow));
		end

	a_dest: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ex_mem.dest == $past(ref_dest))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.dest expected %0d actual %0d",
				$time, $past(ref_dest), $sampled(ex_mem.dest));
		end

	a_store: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ex_mem.store_data == $past(ref_rt))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.store_data expected %h actual %h",
				$time, $past(ref_rt), $sampled(ex_mem.store_data));
		end

	a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> {ex_mem.mem, ex_mem.wb} == $past(ref_ctrl))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.mem/wb expected %b actual %b",
				$time, $past(ref_ctrl), $sampled({ex_mem.mem, ex_mem.wb}));
		end

	// MEM/WB one cycle after EX/MEM
	a_wb: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> wb == $past(ref_wb))
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t wb expected %h actual %h",
				$time, $past(ref_wb), $sampled(wb));
		end

	// Controls right after reset release
	a_reset: assert property (@(posedge clk) $rose(rst_n) |->
		{ex_mem.mem, ex_mem.wb, wb.reg_write} == '0)
		else
		begin
			err_cnt++;
			$error("[ERROR] %0t ex_mem.mem/wb and wb.reg_write expected 0 actual %b",
				$time, $sampled({ex_mem.mem, ex_mem.wb, wb.reg_write}));
		end

endmodule

bind ex_pipe_top ex_pipe_props props_i (.*);

// ==== ex_pipe_tb.sv ====
// Testbench top for the execute and write-back pipeline with a write-back scoreboard
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_pipe_tb;

	// Scoreboard entry, one per issue slot
	typedef struct packed {
		logic               chk;  // Compare wb.data with data
		logic               rw;
		logic               m2r;  // Load, data comes from the next slot's load_data
		logic [`DATA_W-1:0] data;
		logic [`DATA_W-1:0] ld;   // load_data driven in this slot
	} sb_t;

	// Sum of test lengths in cycles plus margin
	localparam int CYCLE_LIMIT = 9 + 63 + 8 + 9 + 3 + 4 + 2 + 20;

	logic                clk;
	logic                rst_n;
	pipe_pkg::ex_issue_t issue;
	logic                flush;
	logic [`DATA_W-1:0]  load_data;
	pipe_pkg::ex_mem_t   ex_mem;
	pipe_pkg::wb_bus_t   wb;

	int                  seed = 2095;
	int                  errors = 0;
	int                  checks = 0;
	int                  cycles = 0;
	int                  total_fail;
	sb_t                 sb_q[$];
	logic [`FUNCT_W-1:0] funct_list [12];

	tb_clk_gen tb_clk_gen_i (.clk(clk), .rst_n(rst_n));

	ex_pipe_top ex_pipe_top_i (
		.clk(clk), .rst_n(rst_n), .issue(issue), .flush(flush),
		.load_data(load_data), .ex_mem(ex_mem), .wb(wb)
	);

	// Hard stop on a hung run
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Scoreboard errors plus failed bound assertions
	function automatic int fail_count();
		return errors + ex_pipe_top_i.props_i.err_cnt;
	endfunction

	function automatic pipe_pkg::ex_issue_t make_issue(
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [31:0] d1, input logic [31:0] d2, input logic [31:0] imm,
		input isa_pkg::alu_op_e op, input logic reg_dst, input logic alu_src,
		input logic reg_write, input logic mem_to_reg
	);
		pipe_pkg::ex_issue_t i;
		i = '0;
		i.rs = rs;
		i.rt = rt;
		i.rd = rd;
		i.data_1 = d1;
		i.data_2 = d2;
		i.imm = imm;
		i.alu_op = op;
		i.reg_dst = reg_dst;
		i.alu_src = alu_src;
		i.mem.mem_read = mem_to_reg; // Loads read memory
		i.wb.reg_write = reg_write;
		i.wb.mem_to_reg = mem_to_reg;
		return i;
	endfunction

	// Compare wb with the instruction issued two slots back
	task automatic check_wb();
		sb_t                e;
		logic [`DATA_W-1:0] exp;
		if (sb_q.size() < 2)
			return;
		e = sb_q.pop_front();
		exp = e.m2r ? sb_q[0].ld : e.data;
		checks++;
		if (wb.reg_write !== e.rw)
		begin
			errors++;
			$display("[ERROR] %0t wb.reg_write expected %0b actual %0b", $time, e.rw, wb.reg_write);
		end
		if ((e.chk || e.m2r) && (wb.data !== exp))
		begin
			errors++;
			$display("[ERROR] %0t wb.data expected %h actual %h", $time, exp, wb.data);
		end
	endtask

	// One issue slot, driven on the falling edge
	task automatic step(input pipe_pkg::ex_issue_t ins, input logic fl,
		input logic chk, input logic [31:0] exp);
		sb_t e;
		@(negedge clk);
		check_wb();
		issue = ins;
		flush = fl;
		load_data = $random(seed);
		e.chk = chk;
		e.rw = fl ? 1'b0 : ins.wb.reg_write;
		e.m2r = fl ? 1'b0 : ins.wb.mem_to_reg;
		e.data = exp;
		e.ld = load_data;
		sb_q.push_back(e);
	endtask

	task automatic test_done(input string name, input int err_before);
		$display("Test %s finished with %0d errors", name, fail_count() - err_before);
	endtask

	initial
	begin
		int                  e0;
		pipe_pkg::ex_issue_t ins;
		issue = '0;
		flush = 1'b0;
		load_data = '0;
		funct_list = '{6'd3, 6'd24, 6'd26, 6'd32, 6'd33, 6'd34,
			6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd0}; // Last one illegal
		@(posedge rst_n);

		// ------------------------------------------------------------
		// ALU operations, no register overlap
		// ------------------------------------------------------------
		e0 = fail_count();
		for (int f = 0; f < 12; f++)
			for (int r = 0; r < 4; r++)
				step(make_issue(1, 2, 3, $random(seed), (r == 0) ? 0 : $random(seed),
					{26'h0, funct_list[f]}, isa_pkg::op_rtype, 1, 0, 0, 0), 0, 0, 0);
		for (int r = 0; r < 12; r++)
			step(make_issue(1, 2, 3, $random(seed), $random(seed), $random(seed),
				isa_pkg::alu_op_e'(r % 4 == 2 ? 3 : r % 4), 1, 0, 0, 0), 0, 0, 0);
		step(make_issue(1, 2, 3, 77, 0, 26, isa_pkg::op_rtype, 1, 0, 0, 0), 0, 0, 0);
		step(make_issue(1, 2, 3, 32'h7fffffff, 1, 32, isa_pkg::op_rtype, 1, 0, 0, 0), 0, 0, 0);
		step(make_issue(1, 2, 3, 32'h7fffffff, 1, 33, isa_pkg::op_rtype, 1, 0, 0, 0), 0, 0, 0);
		test_done("alu_ops", e0);

		// Immediate and destination select
		e0 = fail_count();
		for (int i = 0; i < 8; i++)
		begin
			ins = make_issue(1, 2, 3 + i, $random(seed), $random(seed), $random(seed),
				isa_pkg::op_add, i[0], i[1], 0, 0);
			ins.mem = i[2:0]; // Walk the memory controls through EX/MEM
			step(ins, 0, 0, 0);
		end
		test_done("imm_dest", e0);

		// ------------------------------------------------------------
		// Forwarding, expected sums worked out by hand
		// ------------------------------------------------------------
		e0 = fail_count();
		step(make_issue(1, 2, 5, 10, 20, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 30);
		step(make_issue(5, 2, 6, 999, 1, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 31);
		// rs from wb, rt from EX/MEM
		step(make_issue(5, 6, 7, 999, 999, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 61);
		// rt from wb
		step(make_issue(1, 6, 8, 100, 999, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 131);
		step(make_issue(1, 2, 8, 7, 0, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 7);
		step(make_issue(8, 0, 9, 999, 0, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 7);
		step(make_issue(1, 2, 0, 50, 5, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 55);
		step(make_issue(0, 0, 10, 1, 2, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 3);
		step(make_issue(0, 0, 10, 1, 2, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 3);
		test_done("forwarding", e0);

		// Flushed result is neither written nor forwarded
		e0 = fail_count();
		ins = make_issue(1, 2, 11, 40, 2, 32, isa_pkg::op_rtype, 1, 0, 1, 1);
		ins.mem = '1; // Every control bit set, the flush clears them all
		step(ins, 1, 1, 42);
		step(make_issue(11, 0, 12, 5, 0, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 5);
		step(make_issue(11, 0, 13, 6, 0, 32, isa_pkg::op_rtype, 1, 0, 1, 0), 0, 1, 6);
		test_done("flush", e0);

		// Load data against ALU result on write-back
		e0 = fail_count();
		step(make_issue(1, 14, 0, 100, 0, 4, isa_pkg::op_add, 0, 1, 1, 1), 0, 0, 0);
		step(make_issue(1, 15, 0, 100, 0, 8, isa_pkg::op_add, 0, 1, 1, 0), 0, 1, 108);
		step(make_issue(1, 16, 0, $random(seed), 0, 12, isa_pkg::op_add, 0, 1, 1, 1), 0, 0, 0);
		step(make_issue(1, 17, 0, $random(seed), 0, 16, isa_pkg::op_add, 0, 1, 1, 1), 0, 0, 0);
		step('0, 0, 0, 0); // Drain
		step('0, 0, 0, 0);
		test_done("wb_select", e0);

		total_fail = fail_count();
		$display("Checks passed: %0d, failed: %0d", checks - errors, total_fail);
		if (total_fail == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fwd_unit.sv
alu_decode.sv
alu.sv
ex_stage.sv
wb_stage.sv
ex_pipe_top.sv
tb_clk_gen.sv
ex_pipe_props.sv
ex_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
	--top-module ex_pipe_tb \
	-Mdir obj_dir \
	-f build.f

# Keep going past failed assertions so the testbench prints its summary
./obj_dir/Vex_pipe_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log
then
	exit 0
fi
exit 1
